// ==== cpu_top.f ====
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_decoder.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_wb_master.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
verification/cpu_top_props.sv
verification/cpu_top_tb.sv

// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch address after reset
`define CPU_RESET_VECTOR 32'h0000_0000

// data and address width
`define CPU_XLEN 32

// architectural registers, x0 included
`define CPU_NUM_REGS 32

// pc step per instruction, in bytes
`define CPU_INSTR_LEN 32'd4

// major opcodes, instr[6:0]
// register-register arithmetic
`define CPU_OP_OP     7'b0110011
// register-immediate arithmetic
`define CPU_OP_OPIMM  7'b0010011
`define CPU_OP_LUI    7'b0110111
`define CPU_OP_AUIPC  7'b0010111
`define CPU_OP_JAL    7'b1101111
`define CPU_OP_JALR   7'b1100111
// all six conditional branches
`define CPU_OP_BRANCH 7'b1100011
// only lw is implemented
`define CPU_OP_LOAD   7'b0000011
// only sw is implemented
`define CPU_OP_STORE  7'b0100011

`endif

// ==== run.sh ====
#!/bin/sh
# compile and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module cpu_top_tb \
   -Mdir "$OBJ" -o cpu_top_sim -f cpu_top.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

"./$OBJ/cpu_top_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
   exit 1
fi
exit 0

// ==== verification/cpu_top_props.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top_props
   import cpu_pkg::*;
(
   input logic  clk,
   input logic  reset,
   input logic  wb_ack_i,
   input word_t wb_adr_o,
   input word_t wb_dat_o,
   input logic  wb_cyc_o,
   input logic  wb_stb_o,
   input logic  wb_we_o
);

   // read back by the testbench at the end of the run
   int unsigned fail_count = 0;

   // bus idle while reset is applied
   idle_in_reset: assert property (@(posedge clk)
      reset |=> !wb_cyc_o && !wb_stb_o && !wb_we_o)
      else begin
         $error("bus not idle after a reset cycle");
         fail_count++;
      end

   // first transfer out of reset is a read of the reset vector
   first_fetch: assert property (@(posedge clk)
      $fell(reset) |=> wb_cyc_o && !wb_we_o && wb_adr_o == `CPU_RESET_VECTOR)
      else begin
         $error("first bus cycle is not a fetch at the reset vector");
         fail_count++;
      end

   // request frozen until the slave acks, cyc held with stb
   hold_until_ack: assert property (@(posedge clk) disable iff (reset)
      (wb_stb_o && !wb_ack_i) |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o) &&
                                 $stable(wb_we_o) && $stable(wb_dat_o))
      else begin
         $error("request changed or dropped before ack");
         fail_count++;
      end

   // also gives the idle cycle between transfers
   release_after_ack: assert property (@(posedge clk) disable iff (reset)
      (wb_stb_o && wb_ack_i) |=> !wb_cyc_o && !wb_stb_o)
      else begin
         $error("bus still requested the cycle after ack");
         fail_count++;
      end

   // word accesses only, store data fully driven
   word_access: assert property (@(posedge clk) disable iff (reset)
      wb_stb_o |-> wb_adr_o[1:0] == 2'b00 && !(wb_we_o && $isunknown(wb_dat_o)))
      else begin
         $error("unaligned address or unknown store data");
         fail_count++;
      end

endmodule

// ==== verification/cpu_top_tb.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top_tb
   import cpu_pkg::*;
();

   // program below, data from here up
   localparam word_t DATA_BASE   = 32'h0000_0200;
   localparam word_t MARKER_ADDR = 32'h0000_03fc;
   localparam word_t LOAD_ADDR   = 32'h0000_0300;
   localparam int    SELF_JUMPS  = 3;
   localparam int    NUM_TESTS   = 4;

   logic   clk = 1'b0;
   logic   reset = 1'b1;
   logic   wb_ack_i = 1'b0;
   word_t  wb_dat_i = '0;
   word_t  wb_adr_o;
   word_t  wb_dat_o;
   logic   wb_cyc_o;
   logic   wb_stb_o;
   logic   wb_we_o;

   word_t  mem [0:255];
   // expected fetch after each program word
   word_t  succ [0:255];
   word_t  exp_addr [$];
   word_t  exp_data [$];
   string  test_name [1:NUM_TESTS];
   word_t  pc_emit;
   word_t  end_pc;
   word_t  next_fetch = `CPU_RESET_VECTOR;
   integer seed = 32'h4fb7164b;
   int     wait_left = 0;
   logic   waiting = 1'b0;
   int     cycles = 0;
   int     cycle_limit = 0;
   int     errors = 0;
   int     errors_at_test = 0;
   int     stores = 0;
   int     self_jumps = 0;
   int     tests_done = 0;

   always #20 clk = ~clk;

   cpu_top cpu_top_i (
      .clk      (clk),
      .reset    (reset),
      .wb_ack_i (wb_ack_i),
      .wb_dat_i (wb_dat_i),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o)
   );

   bind cpu_top cpu_top_props props_i (
      .clk      (clk),
      .reset    (reset),
      .wb_ack_i (wb_ack_i),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o)
   );

   // rv32i instruction formats
   function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3,
                                    input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, `CPU_OP_OP};
   endfunction

   function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd,
                                    input logic [6:0] opcode);
      return {imm, rs1, f3, rd, opcode};
   endfunction

   // sw only
   function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `CPU_OP_STORE};
   endfunction

   function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `CPU_OP_BRANCH};
   endfunction

   function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] opcode);
      return {imm, rd, opcode};
   endfunction

   function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `CPU_OP_JAL};
   endfunction

   task automatic emit_to(input word_t instr, input word_t next);
      mem[pc_emit[9:2]] = instr;
      succ[pc_emit[9:2]] = next;
      pc_emit = pc_emit + 4;
   endtask

   task automatic emit(input word_t instr);
      emit_to(instr, pc_emit + 4);
   endtask

   // sw rs2 to a fixed address, queue the word it has to carry
   task automatic store_expect(input reg_addr_t rs2, input logic [11:0] addr,
                               input word_t value);
      emit(s_type(addr, rs2, 5'd0));
      exp_addr.push_back({20'd0, addr});
      exp_data.push_back(value);
   endtask

   // end of test n, seen as a store of n to the marker word
   task automatic marker(input logic [11:0] n);
      emit(i_type(n, 5'd0, 3'b000, 5'd31, `CPU_OP_OPIMM));
      emit(s_type(MARKER_ADDR[11:0], 5'd31, 5'd0));
   endtask

   task automatic build_program();
      word_t x1;
      word_t x2;
      word_t link;
      int    i;
      x1 = 32'h1234_5678;
      x2 = 32'hffff_fffb;
      for (i = 0; i < 256; i++) begin
         mem[i] = 32'h5a00_0000 ^ (word_t'(i) << 2);
      end
      mem[LOAD_ADDR[9:2]] = 32'hcafe_0000;
      pc_emit = `CPU_RESET_VECTOR;
      // alu chain, x1 = 0x12345678 and x2 = -5
      emit(u_type(20'h12345, 5'd1, `CPU_OP_LUI));
      emit(i_type(12'h678, 5'd1, 3'b000, 5'd1, `CPU_OP_OPIMM));
      emit(i_type(12'hffb, 5'd0, 3'b000, 5'd2, `CPU_OP_OPIMM));
      emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
      store_expect(5'd3, 12'h200, x1 - x2);
      // srai by 1, imm bit 10 picks arithmetic
      emit(i_type(12'h401, 5'd2, 3'b101, 5'd4, `CPU_OP_OPIMM));
      store_expect(5'd4, 12'h204, {x2[31], x2[31:1]});
      // sltu, x1 is below x2 unsigned
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd5));
      store_expect(5'd5, 12'h208, 32'd1);
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd6));
      store_expect(5'd6, 12'h20c, x1 ^ x2);
      // auipc adds to its own pc
      link = pc_emit + 32'h0000_1000;
      emit(u_type(20'h00001, 5'd7, `CPU_OP_AUIPC));
      store_expect(5'd7, 12'h210, link);
      marker(12'd1);
      // load round trip
      emit(i_type(LOAD_ADDR[11:0], 5'd0, 3'b010, 5'd8, `CPU_OP_LOAD));
      emit(i_type(12'h123, 5'd8, 3'b000, 5'd9, `CPU_OP_OPIMM));
      store_expect(5'd9, 12'h214, 32'hcafe_0000 + 32'h123);
      marker(12'd2);
      // x10 = 3, beq falls through, bne skips a stray store
      emit(i_type(12'd3, 5'd0, 3'b000, 5'd10, `CPU_OP_OPIMM));
      emit(b_type(13'd8, 5'd0, 5'd10, 3'b000));
      emit_to(b_type(13'd8, 5'd0, 5'd10, 3'b001), pc_emit + 8);
      emit(s_type(12'h3f8, 5'd10, 5'd0));
      link = pc_emit + 4;
      emit_to(j_type(21'd8, 5'd12), pc_emit + 8);
      emit(s_type(12'h3f8, 5'd10, 5'd0));
      store_expect(5'd12, 12'h218, link);
      // jalr through x13, lands past one stray store
      emit(i_type(12'(pc_emit + 12), 5'd0, 3'b000, 5'd13, `CPU_OP_OPIMM));
      link = pc_emit + 4;
      emit_to(i_type(12'd0, 5'd13, 3'b000, 5'd14, `CPU_OP_JALR), pc_emit + 8);
      emit(s_type(12'h3f8, 5'd10, 5'd0));
      store_expect(5'd14, 12'h21c, link);
      marker(12'd3);
      // write to x0 then store it
      emit(i_type(12'h055, 5'd0, 3'b000, 5'd0, `CPU_OP_OPIMM));
      store_expect(5'd0, 12'h220, 32'd0);
      marker(12'd4);
      end_pc = pc_emit;
      emit_to(j_type(21'd0, 5'd0), pc_emit);
      // about 12 cycles worst case per instruction
      cycle_limit = (int'(pc_emit[9:2]) + SELF_JUMPS) * 12 + 100;
   endtask

   task automatic report_mismatch(input string sig, input word_t expected, input word_t got);
      $display("mismatch at %0t: %s expected %h, got %h", $time, sig, expected, got);
      errors++;
   endtask

   task automatic finish_test();
      tests_done++;
      assert (wb_dat_o == word_t'(tests_done))
         else report_mismatch("wb_dat_o", word_t'(tests_done), wb_dat_o);
      if (tests_done <= NUM_TESTS) begin
         $display("test %0d %s finished, %0d errors", tests_done, test_name[tests_done],
                  errors - errors_at_test);
      end
      errors_at_test = errors;
   endtask

   // transfer completes in the cycle ack is raised
   task automatic complete_access();
      word_t ea;
      word_t ed;
      if (wb_we_o) begin
         mem[wb_adr_o[9:2]] = wb_dat_o;
         stores++;
         if (wb_adr_o == MARKER_ADDR) begin
            finish_test();
         end else if (exp_addr.size() == 0) begin
            $display("unexpected store of %h to %h at %0t", wb_dat_o, wb_adr_o, $time);
            errors++;
         end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (wb_adr_o == ea) else report_mismatch("wb_adr_o", ea, wb_adr_o);
            assert (wb_dat_o == ed) else report_mismatch("wb_dat_o", ed, wb_dat_o);
         end
      end else begin
         wb_dat_i = mem[wb_adr_o[9:2]];
         // fetches are the reads below the data region
         if (wb_adr_o < DATA_BASE) begin
            assert (wb_adr_o == next_fetch)
               else report_mismatch("wb_adr_o", next_fetch, wb_adr_o);
            if (wb_adr_o == end_pc) begin
               self_jumps++;
            end
            next_fetch = succ[wb_adr_o[9:2]];
         end
      end
   endtask

   // slave, ack after 0 to 3 cycles
   always @(negedge clk) begin
      if (reset) begin
         wb_ack_i = 1'b0;
         waiting = 1'b0;
      end else if (wb_ack_i) begin
         wb_ack_i = 1'b0;
      end else if (wb_stb_o) begin
         if (!waiting) begin
            waiting = 1'b1;
            wait_left = $random(seed) & 3;
         end
         if (wait_left == 0) begin
            waiting = 1'b0;
            complete_access();
            wb_ack_i = 1'b1;
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         cycles <= cycles + 1;
      end
   end

   initial begin : main
      int   end_errors;
      int   prop_fails;
      logic timed_out;
      end_errors = 0;
      timed_out = 1'b0;
      test_name[1] = "alu";
      test_name[2] = "load";
      test_name[3] = "control";
      test_name[4] = "x0";
      build_program();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      // run until the final loop has been fetched a few times
      while (self_jumps < SELF_JUMPS && !timed_out) begin
         @(negedge clk);
         if (cycles >= cycle_limit) begin
            timed_out = 1'b1;
         end
      end
      if (timed_out) begin
         $display("timeout after %0d cycles, the final loop was not reached", cycles);
         end_errors++;
      end
      assert (tests_done == NUM_TESTS) else begin
         $display("only %0d of %0d tests finished", tests_done, NUM_TESTS);
         end_errors++;
      end
      assert (exp_addr.size() == 0) else begin
         $display("%0d expected stores never happened", exp_addr.size());
         end_errors++;
      end
      prop_fails = int'(cpu_top_i.props_i.fail_count);
      $display("tests %0d, stores %0d, self-jump fetches %0d, errors %0d, property fails %0d",
               tests_done, stores, self_jumps, errors + end_errors, prop_fails);
      if (errors + end_errors + prop_fails == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_alu
   import cpu_pkg::*;
(
   input  alu_op_e   op_i,
   input  alu_src1_e src1_i,
   input  alu_src2_e src2_i,
   input  word_t     rval1_i,
   input  word_t     rval2_i,
   input  word_t     imm_i,
   input  word_t     pc_i,
   input  funct3_t   funct3_i,
   output word_t     result_o,
   output logic      branch_taken_o
);

   word_t op_a;
   word_t op_b;
   word_t sum;
   logic  eq;
   logic  lt_s;
   logic  lt_u;
   logic  cond;

   // operand muxes
   assign op_a = (src1_i == SRC1_PC) ? pc_i : rval1_i;

   always_comb begin
      case (src2_i)
         SRC2_REG: op_b = rval2_i;
         SRC2_IMM: op_b = imm_i;
         default:  op_b = `CPU_INSTR_LEN;
      endcase
   end

   assign sum = op_a + op_b;

   // anything with pc as operand is address math, so always an add
   // this lets decode form pc+4 whatever the latched op is
   always_comb begin
      if (src1_i == SRC1_PC) begin
         result_o = sum;
      end else begin
         case (op_i)
            ALU_SUB:  result_o = op_a - op_b;
            ALU_SLL:  result_o = op_a << op_b[4:0];
            ALU_SLT:  result_o = {{(`CPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result_o = {{(`CPU_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result_o = op_a ^ op_b;
            ALU_SRL:  result_o = op_a >> op_b[4:0];
            ALU_SRA:  result_o = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   result_o = op_a | op_b;
            ALU_AND:  result_o = op_a & op_b;
            default:  result_o = sum;
         endcase
      end
   end

   // branch compare always on the raw register values
   assign eq   = rval1_i == rval2_i;
   assign lt_s = $signed(rval1_i) < $signed(rval2_i);
   assign lt_u = rval1_i < rval2_i;

   // funct3[2:1] picks the test, funct3[0] inverts it
   always_comb begin
      case (funct3_i[2:1])
         2'b00:   cond = eq;
         2'b10:   cond = lt_s;
         2'b11:   cond = lt_u;
         default: cond = 1'b0;
      endcase
   end

   // 01x is not a branch encoding, never taken
   assign branch_taken_o = (funct3_i[2:1] != 2'b01) && (cond ^ funct3_i[0]);

endmodule

// ==== verilog/cpu_control.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_control
   import cpu_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         bus_done_i,
   input  word_t        bus_rdata_i,
   output logic         bus_start_o,
   output logic         bus_we_o,
   output word_t        bus_addr_o,
   output word_t        bus_wdata_o,
   output word_t        instr_o,
   output word_t        pc_o,
   input  instr_class_e class_i,
   input  logic         write_reg_i,
   input  word_t        alu_result_i,
   input  logic         branch_taken_i,
   input  word_t        imm_i,
   input  word_t        rval2_i,
   output logic         reg_re_o,
   output logic         reg_we_o,
   output word_t        reg_wdata_o,
   output alu_src1_e    alu_src1_o,
   output alu_src2_e    alu_src2_o,
   input  alu_src1_e    decoder_src1_i,
   input  alu_src2_e    decoder_src2_i
);

   cpu_state_e state_q;
   cpu_state_e state_d;
   word_t      pc_q;
   word_t      pc_d;
   word_t      pc_plus4_q;
   // alu result of exec: target, address or op result
   word_t      target_q;
   word_t      instr_q;
   logic       taken_q;
   logic       mem_access;
   logic       redirect;

   assign mem_access = (class_i == CLASS_LOAD) || (class_i == CLASS_STORE);

   always_comb begin
      case (state_q)
         ST_RESET:     state_d = ST_FETCH;
         ST_FETCH:     state_d = bus_done_i ? ST_DECODE : ST_FETCH;
         ST_DECODE:    state_d = ST_EXEC;
         ST_EXEC:      state_d = mem_access ? ST_MEM : ST_WRITEBACK;
         ST_MEM:       state_d = bus_done_i ? ST_WRITEBACK : ST_MEM;
         ST_WRITEBACK: state_d = ST_FETCH;
         default:      state_d = ST_RESET;
      endcase
   end

   // jumps always leave the fall-through path, branches only when taken
   assign redirect = (class_i == CLASS_JUMP) || (class_i == CLASS_BRANCH && taken_q);

   // pc only moves at the end of writeback
   // bit 0 of a target is cleared, as jalr requires
   always_comb begin
      pc_d = pc_q;
      if (state_q == ST_WRITEBACK) begin
         pc_d = redirect ? {target_q[`CPU_XLEN-1:1], 1'b0} : pc_plus4_q;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ST_RESET;
         pc_q    <= `CPU_RESET_VECTOR;
         taken_q <= 1'b0;
      end else begin
         state_q <= state_d;
         pc_q    <= pc_d;
         if (state_q == ST_EXEC) begin
            taken_q <= branch_taken_i;
         end
      end
   end

   always_ff @(posedge clk) begin
      // instruction latched with the fetch done pulse
      if (state_q == ST_FETCH && bus_done_i) begin
         instr_q <= bus_rdata_i;
      end
      // decode: alu gives pc+4
      if (state_q == ST_DECODE) begin
         pc_plus4_q <= alu_result_i;
      end
      if (state_q == ST_EXEC) begin
         target_q <= alu_result_i;
      end
   end

   // fetch request issued in reset and writeback, data access in exec
   assign bus_start_o = (state_q == ST_RESET) || (state_q == ST_WRITEBACK) ||
                        (state_q == ST_EXEC && mem_access);
   assign bus_we_o    = (state_q == ST_EXEC) && (class_i == CLASS_STORE);
   // in writeback the fetch goes to the pc being loaded
   assign bus_addr_o  = (state_q == ST_EXEC) ? alu_result_i : pc_d;
   assign bus_wdata_o = rval2_i;

   assign instr_o = instr_q;
   assign pc_o    = pc_q;

   // registers read once, outputs hold through writeback
   assign reg_re_o = state_q == ST_DECODE;
   assign reg_we_o = (state_q == ST_WRITEBACK) && write_reg_i;

   always_comb begin
      case (class_i)
         CLASS_JUMP: reg_wdata_o = pc_plus4_q;
         CLASS_LUI:  reg_wdata_o = imm_i;
         CLASS_LOAD: reg_wdata_o = bus_rdata_i;
         default:    reg_wdata_o = target_q;
      endcase
   end

   // decode borrows the alu for pc + ilen
   assign alu_src1_o = (state_q == ST_DECODE) ? SRC1_PC : decoder_src1_i;
   assign alu_src2_o = (state_q == ST_DECODE) ? SRC2_ILEN : decoder_src2_i;

endmodule

// ==== verilog/cpu_decoder.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_decoder
   import cpu_pkg::*;
(
   input  word_t        instr_i,
   output reg_addr_t    rs1_o,
   output reg_addr_t    rs2_o,
   output reg_addr_t    rd_o,
   output word_t        imm_o,
   output funct3_t      funct3_o,
   output alu_op_e      alu_op_o,
   output alu_src1_e    src1_o,
   output alu_src2_e    src2_o,
   output instr_class_e class_o,
   output logic         write_reg_o
);

   logic [6:0] opcode;
   // funct7 bit 5, sub and sra
   logic       alt_bit;
   word_t      imm_i_type;
   word_t      imm_s_type;
   word_t      imm_b_type;
   word_t      imm_u_type;
   word_t      imm_j_type;
   alu_op_e    arith_op;

   // fixed field positions
   assign opcode   = instr_i[6:0];
   assign rd_o     = instr_i[11:7];
   assign funct3_o = instr_i[14:12];
   assign rs1_o    = instr_i[19:15];
   assign rs2_o    = instr_i[24:20];
   assign alt_bit  = instr_i[30];

   // immediate formats, all sign extended from bit 31
   assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
   assign imm_u_type = {instr_i[31:12], 12'b0};
   assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

   // op and op-imm share funct3 encoding
   always_comb begin
      case (funct3_o)
         // addi has no sub form, bit 30 is imm there
         3'b000:  arith_op = (alt_bit && opcode == `CPU_OP_OP) ? ALU_SUB : ALU_ADD;
         3'b001:  arith_op = ALU_SLL;
         3'b010:  arith_op = ALU_SLT;
         3'b011:  arith_op = ALU_SLTU;
         3'b100:  arith_op = ALU_XOR;
         3'b101:  arith_op = alt_bit ? ALU_SRA : ALU_SRL;
         3'b110:  arith_op = ALU_OR;
         default: arith_op = ALU_AND;
      endcase
   end

   // defaults fit rs1 + imm forms (jalr, lw)
   always_comb begin
      imm_o    = imm_i_type;
      alu_op_o = ALU_ADD;
      src1_o   = SRC1_REG;
      src2_o   = SRC2_IMM;
      class_o  = CLASS_NOP;
      case (opcode)
         `CPU_OP_OP: begin
            alu_op_o = arith_op;
            src2_o   = SRC2_REG;
            class_o  = CLASS_ALU;
         end
         `CPU_OP_OPIMM: begin
            alu_op_o = arith_op;
            class_o  = CLASS_ALU;
         end
         `CPU_OP_LUI: begin
            imm_o   = imm_u_type;
            class_o = CLASS_LUI;
         end
         // pc + upper imm goes through the alu path
         `CPU_OP_AUIPC: begin
            imm_o   = imm_u_type;
            src1_o  = SRC1_PC;
            class_o = CLASS_ALU;
         end
         `CPU_OP_JAL: begin
            imm_o   = imm_j_type;
            src1_o  = SRC1_PC;
            class_o = CLASS_JUMP;
         end
         `CPU_OP_JALR: class_o = CLASS_JUMP;
         // alu forms the target, compare is separate
         `CPU_OP_BRANCH: begin
            imm_o   = imm_b_type;
            src1_o  = SRC1_PC;
            class_o = CLASS_BRANCH;
         end
         `CPU_OP_LOAD: class_o = CLASS_LOAD;
         `CPU_OP_STORE: begin
            imm_o   = imm_s_type;
            class_o = CLASS_STORE;
         end
         // fence, system and unknown run as nops
         default: class_o = CLASS_NOP;
      endcase
   end

   assign write_reg_o = (class_o == CLASS_ALU) || (class_o == CLASS_LUI) ||
                        (class_o == CLASS_JUMP) || (class_o == CLASS_LOAD);

endmodule

// ==== verilog/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

   // data, address or instruction word
   typedef logic [`CPU_XLEN-1:0] word_t;

   // register index
   typedef logic [4:0] reg_addr_t;

   // instr[14:12]
   typedef logic [2:0] funct3_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   // first operand
   typedef enum logic {
      SRC1_REG,
      SRC1_PC
   } alu_src1_e;

   // second operand, ilen is the pc increment
   typedef enum logic [1:0] {
      SRC2_REG,
      SRC2_IMM,
      SRC2_ILEN
   } alu_src2_e;

   // picks mem step, writeback source and next pc
   typedef enum logic [2:0] {
      CLASS_ALU,
      CLASS_LUI,
      CLASS_JUMP,
      CLASS_BRANCH,
      CLASS_LOAD,
      CLASS_STORE,
      CLASS_NOP
   } instr_class_e;

   typedef enum logic [2:0] {
      ST_RESET,
      ST_FETCH,
      ST_DECODE,
      ST_EXEC,
      ST_MEM,
      ST_WRITEBACK
   } cpu_state_e;

endpackage

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_regfile
   import cpu_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  reg_addr_t rs1_i,
   input  reg_addr_t rs2_i,
   input  reg_addr_t rd_i,
   input  logic      re_i,
   input  logic      we_i,
   input  word_t     wdata_i,
   output word_t     rdata1_o,
   output word_t     rdata2_o
);

   // no storage behind x0
   word_t regs [1:`CPU_NUM_REGS-1];

   // writes to x0 are dropped
   always_ff @(posedge clk) begin
      if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // read ports, held until the next re_i
   always_ff @(posedge clk) begin
      if (reset) begin
         rdata1_o <= '0;
         rdata2_o <= '0;
      end else if (re_i) begin
         rdata1_o <= (rs1_i == '0) ? '0 : regs[rs1_i];
         rdata2_o <= (rs2_i == '0) ? '0 : regs[rs2_i];
      end
   end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top
   import cpu_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  wb_ack_i,
   input  word_t wb_dat_i,
   output word_t wb_adr_o,
   output word_t wb_dat_o,
   output logic  wb_cyc_o,
   output logic  wb_stb_o,
   output logic  wb_we_o
);

   // sequencer to bus master
   logic         bus_start;
   logic         bus_we;
   word_t        bus_addr;
   word_t        bus_wdata;
   logic         bus_done;
   word_t        bus_rdata;
   // decoder outputs
   word_t        instr;
   word_t        pc;
   reg_addr_t    rs1;
   reg_addr_t    rs2;
   reg_addr_t    rd;
   word_t        imm;
   funct3_t      funct3;
   alu_op_e      alu_op;
   alu_src1_e    dec_src1;
   alu_src2_e    dec_src2;
   instr_class_e iclass;
   logic         write_reg;
   // operands after the decode override
   alu_src1_e    alu_src1;
   alu_src2_e    alu_src2;
   word_t        rval1;
   word_t        rval2;
   logic         reg_re;
   logic         reg_we;
   word_t        reg_wdata;
   word_t        alu_result;
   logic         branch_taken;

   cpu_control cpu_control_i (
      .clk            (clk),
      .reset          (reset),
      .bus_done_i     (bus_done),
      .bus_rdata_i    (bus_rdata),
      .bus_start_o    (bus_start),
      .bus_we_o       (bus_we),
      .bus_addr_o     (bus_addr),
      .bus_wdata_o    (bus_wdata),
      .instr_o        (instr),
      .pc_o           (pc),
      .class_i        (iclass),
      .write_reg_i    (write_reg),
      .alu_result_i   (alu_result),
      .branch_taken_i (branch_taken),
      .imm_i          (imm),
      .rval2_i        (rval2),
      .reg_re_o       (reg_re),
      .reg_we_o       (reg_we),
      .reg_wdata_o    (reg_wdata),
      .alu_src1_o     (alu_src1),
      .alu_src2_o     (alu_src2),
      .decoder_src1_i (dec_src1),
      .decoder_src2_i (dec_src2)
   );

   cpu_decoder cpu_decoder_i (
      .instr_i     (instr),
      .rs1_o       (rs1),
      .rs2_o       (rs2),
      .rd_o        (rd),
      .imm_o       (imm),
      .funct3_o    (funct3),
      .alu_op_o    (alu_op),
      .src1_o      (dec_src1),
      .src2_o      (dec_src2),
      .class_o     (iclass),
      .write_reg_o (write_reg)
   );

   cpu_regfile cpu_regfile_i (
      .clk      (clk),
      .reset    (reset),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .rd_i     (rd),
      .re_i     (reg_re),
      .we_i     (reg_we),
      .wdata_i  (reg_wdata),
      .rdata1_o (rval1),
      .rdata2_o (rval2)
   );

   cpu_alu cpu_alu_i (
      .op_i           (alu_op),
      .src1_i         (alu_src1),
      .src2_i         (alu_src2),
      .rval1_i        (rval1),
      .rval2_i        (rval2),
      .imm_i          (imm),
      .pc_i           (pc),
      .funct3_i       (funct3),
      .result_o       (alu_result),
      .branch_taken_o (branch_taken)
   );

   cpu_wb_master cpu_wb_master_i (
      .clk      (clk),
      .reset    (reset),
      .start_i  (bus_start),
      .we_i     (bus_we),
      .addr_i   (bus_addr),
      .wdata_i  (bus_wdata),
      .done_o   (bus_done),
      .rdata_o  (bus_rdata),
      .wb_ack_i (wb_ack_i),
      .wb_dat_i (wb_dat_i),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o)
   );

endmodule

// ==== verilog/cpu_wb_master.sv ====
`timescale 1ns/100ps

module cpu_wb_master
   import cpu_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  start_i,
   input  logic  we_i,
   input  word_t addr_i,
   input  word_t wdata_i,
   output logic  done_o,
   output word_t rdata_o,
   input  logic  wb_ack_i,
   input  word_t wb_dat_i,
   output word_t wb_adr_o,
   output word_t wb_dat_o,
   output logic  wb_cyc_o,
   output logic  wb_stb_o,
   output logic  wb_we_o
);

   // one flop drives cyc and stb, so they never differ
   logic active_q;

   // control side of the bus cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         active_q <= 1'b0;
         wb_we_o  <= 1'b0;
         done_o   <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (active_q && wb_ack_i) begin
            // ack sampled, release the bus next cycle
            active_q <= 1'b0;
            wb_we_o  <= 1'b0;
            done_o   <= 1'b1;
         end else if (start_i && !active_q) begin
            active_q <= 1'b1;
            wb_we_o  <= we_i;
         end
      end
   end

   // address and data held for the whole cycle
   always_ff @(posedge clk) begin
      if (start_i && !active_q) begin
         wb_adr_o <= addr_i;
         wb_dat_o <= wdata_i;
      end
      // read data kept until the next ack
      if (active_q && wb_ack_i) begin
         rdata_o <= wb_dat_i;
      end
   end

   assign wb_cyc_o = active_q;
   assign wb_stb_o = active_q;

endmodule
